// ==== include/trace_params.svh ====
//////////////////////////////////////////////////
// Width definitions for the retirement trace unit
// Included by both packages and by the RTL that sizes ports
//////////////////////////////////////////////////
`ifndef TRACE_PARAMS_SVH
`define TRACE_PARAMS_SVH

// Datapath
`define XLEN          32  // PC and instruction word
`define OPCODE_W      7   // RISC-V major opcode field

// Counters, all saturating except the cycle counter
`define CYCLE_W       32  // Free-running cycle count
`define STALL_W       8   // Per-instruction stall count
`define STALL_TOTAL_W 16  // Total stall cycles
`define COUNT_W       16  // Per-class retire count

// Operation classes
`define NUM_CLASSES   9
`define CLASS_W       4

`endif

// ==== hw/rv_isa_pkg.sv ====
//////////////////////////////////////////////////
// Instruction set view of the trace unit
// Major opcodes and the operation classes they retire as
//////////////////////////////////////////////////
`include "trace_params.svh"

package rv_isa_pkg;

  // RISC-V major opcodes, instr[6:0]
  typedef enum logic [`OPCODE_W-1:0] {
    OP     = 7'b0110011,  // Register-register ALU
    OP_IMM = 7'b0010011,  // Register-immediate ALU
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    SYSTEM = 7'b1110011   // ECALL, EBREAK, CSR access
  } opcode_t;

  // Class recorded in the trace, also the retire counter index
  typedef enum logic [`CLASS_W-1:0] {
    CLS_ALU     = 4'd0,
    CLS_ALU_IMM = 4'd1,
    CLS_LOAD    = 4'd2,
    CLS_STORE   = 4'd3,
    CLS_BRANCH  = 4'd4,
    CLS_JUMP    = 4'd5,   // JAL and JALR
    CLS_UPPER   = 4'd6,   // LUI and AUIPC
    CLS_SYSTEM  = 4'd7,
    CLS_ILLEGAL = 4'd8    // Unknown opcode or low bits not 11
  } op_class_t;

endpackage

// ==== hw/trace_pkg.sv ====
//////////////////////////////////////////////////
// Trace machinery types
// Stage indices of the shadow pipeline and counter widths
//////////////////////////////////////////////////
`include "trace_params.svh"

package trace_pkg;

  // Slot index of the shadow pipeline
  typedef enum logic [2:0] {
    STG_IF  = 3'd0,
    STG_ID  = 3'd1,
    STG_EX  = 3'd2,
    STG_MEM = 3'd3,
    STG_WB  = 3'd4
  } stage_t;

  // Time references
  typedef logic [`CYCLE_W-1:0]       cycle_t;        // Edges since reset release
  typedef logic [`STALL_W-1:0]       stall_cnt_t;    // Stall cycles of one instruction
  typedef logic [`STALL_TOTAL_W-1:0] stall_total_t;  // Stall cycles overall

  // Retire statistics
  typedef logic [`COUNT_W-1:0]       class_count_t;

endpackage

// ==== hw/trace_stage_tracker.sv ====
//////////////////////////////////////////////////
// Shadow pipeline of the five core stages
// Follows fetch and stall, presents the WB slot to the recorder
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "trace_params.svh"

module trace_stage_tracker
  import trace_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             fetch_valid,  // Instruction present this cycle
  input  logic [`XLEN-1:0] fetch_pc,
  input  logic [`XLEN-1:0] fetch_instr,
  input  logic             stall,        // Decode stall level from the core
  output logic             ret_valid,    // WB slot holds an instruction
  output logic [`XLEN-1:0] ret_pc,
  output logic [`XLEN-1:0] ret_instr,
  output stall_cnt_t       ret_stalls
);

  //////////////////////////////////////////////////
  // Slot storage, one entry per stage
  //////////////////////////////////////////////////
  logic             slot_valid  [STG_IF:STG_WB];
  logic [`XLEN-1:0] slot_pc     [STG_IF:STG_WB];
  logic [`XLEN-1:0] slot_instr  [STG_IF:STG_WB];
  stall_cnt_t       slot_stalls [STG_IF:STG_WB];  // Cycles held in IF or ID

  //////////////////////////////////////////////////
  // Valid bits, the only control state
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = STG_IF; s <= STG_WB; s++) begin
        slot_valid[s] <= 1'b0;  // Pipeline starts empty
      end
    end else begin
      if (!stall) begin
        slot_valid[STG_IF] <= fetch_valid;         // Sample the core's fetch
        slot_valid[STG_ID] <= slot_valid[STG_IF];
        slot_valid[STG_EX] <= slot_valid[STG_ID];
      end else begin
        slot_valid[STG_EX] <= 1'b0;                // Bubble into execute
      end
      // Back end never holds
      slot_valid[STG_MEM] <= slot_valid[STG_EX];
      slot_valid[STG_WB]  <= slot_valid[STG_MEM];
    end
  end

  //////////////////////////////////////////////////
  // Payload movement and stall accounting
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = STG_IF; s <= STG_WB; s++) begin
        slot_pc[s]     <= '0;
        slot_instr[s]  <= '0;
        slot_stalls[s] <= '0;                      // Counters start at zero
      end
    end else begin
      if (!stall) begin
        slot_pc[STG_IF]     <= fetch_pc;
        slot_instr[STG_IF]  <= fetch_instr;
        slot_stalls[STG_IF] <= '0;                 // Fresh instruction, no stalls yet
        for (int s = STG_ID; s <= STG_EX; s++) begin
          slot_pc[s]     <= slot_pc[s-1];
          slot_instr[s]  <= slot_instr[s-1];
          slot_stalls[s] <= slot_stalls[s-1];
        end
      end else begin
        // IF and ID hold, count the held cycle
        for (int s = STG_IF; s <= STG_ID; s++) begin
          if (slot_valid[s] && slot_stalls[s] != '1) begin
            slot_stalls[s] <= slot_stalls[s] + 1'b1;  // Saturates at all ones
          end
        end
      end
      for (int s = STG_MEM; s <= STG_WB; s++) begin
        slot_pc[s]     <= slot_pc[s-1];
        slot_instr[s]  <= slot_instr[s-1];
        slot_stalls[s] <= slot_stalls[s-1];
      end
    end
  end

  // Retiring slot straight out of WB
  assign ret_valid  = slot_valid[STG_WB];
  assign ret_pc     = slot_pc[STG_WB];
  assign ret_instr  = slot_instr[STG_WB];
  assign ret_stalls = slot_stalls[STG_WB];

endmodule

// ==== hw/trace_cycle_timer.sv ====
//////////////////////////////////////////////////
// Time references of the trace
// Free-running cycle count and saturating stall total
//////////////////////////////////////////////////
`timescale 1ns/10ps

module trace_cycle_timer
  import trace_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         stall,        // Decode stall level
  output cycle_t       cycle_now,    // Zero in the first cycle after reset
  output stall_total_t stall_total   // Stall-high cycles seen so far
);

  // Cycle counter, wraps
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      cycle_now <= '0;
    else
      cycle_now <= cycle_now + 1'b1;
  end

  // Stall total, sticks at full scale
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      stall_total <= '0;
    else if (stall && stall_total != '1)
      stall_total <= stall_total + 1'b1;
  end

endmodule

// ==== hw/trace_recorder.sv ====
//////////////////////////////////////////////////
// Trace record builder
// Classifies each retiring instruction, stamps it with the
// cycle and keeps a retire count per operation class
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "trace_params.svh"

module trace_recorder
  import rv_isa_pkg::*;
  import trace_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               ret_valid,     // WB slot valid
  input  logic [`XLEN-1:0]   ret_pc,
  input  logic [`XLEN-1:0]   ret_instr,
  input  stall_cnt_t         ret_stalls,
  input  cycle_t             cycle_now,
  input  logic [`CLASS_W-1:0] class_sel,    // Which retire count to show
  output logic               trace_valid,   // One-cycle record strobe
  output logic [`XLEN-1:0]   trace_pc,
  output op_class_t          trace_class,
  output cycle_t             trace_cycle,   // Cycle of the WB stage
  output stall_cnt_t         trace_stalls,
  output class_count_t       class_count
);

  op_class_t    ret_class;                  // Class of the WB instruction
  class_count_t class_cnt [`NUM_CLASSES];   // Retire count bank

  //////////////////////////////////////////////////
  // Opcode decode
  //////////////////////////////////////////////////
  function automatic op_class_t decode_class(input logic [`XLEN-1:0] instr);
    opcode_t   opc;
    op_class_t cls;
    opc = opcode_t'(instr[`OPCODE_W-1:0]);
    case (opc)
      OP:          cls = CLS_ALU;
      OP_IMM:      cls = CLS_ALU_IMM;
      LOAD:        cls = CLS_LOAD;
      STORE:       cls = CLS_STORE;
      BRANCH:      cls = CLS_BRANCH;
      JAL, JALR:   cls = CLS_JUMP;
      LUI, AUIPC:  cls = CLS_UPPER;
      SYSTEM:      cls = CLS_SYSTEM;
      default:     cls = CLS_ILLEGAL;  // Reserved or custom opcode
    endcase
    if (instr[1:0] != 2'b11)
      cls = CLS_ILLEGAL;               // Compressed or malformed encoding
    return cls;
  endfunction

  assign ret_class = decode_class(ret_instr);

  //////////////////////////////////////////////////
  // Trace record
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      trace_valid <= 1'b0;
    else
      trace_valid <= ret_valid;  // Pulse, WB holds a slot one cycle
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trace_pc     <= '0;
      trace_class  <= CLS_ALU;     // Encoding zero
      trace_cycle  <= '0;
      trace_stalls <= '0;
    end else if (ret_valid) begin
      trace_pc     <= ret_pc;
      trace_class  <= ret_class;
      trace_cycle  <= cycle_now;   // Value during the WB cycle
      trace_stalls <= ret_stalls;
    end
  end

  //////////////////////////////////////////////////
  // Per-class retire counts
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int c = 0; c < `NUM_CLASSES; c++) begin
        class_cnt[c] <= '0;
      end
    end else if (ret_valid && class_cnt[ret_class] != '1) begin
      class_cnt[ret_class] <= class_cnt[ret_class] + 1'b1;  // Saturating
    end
  end

  // Read port, unused select codes read zero
  assign class_count = (int'(class_sel) < `NUM_CLASSES) ? class_cnt[class_sel] : '0;

endmodule

// ==== hw/pipeline_trace_top.sv ====
//////////////////////////////////////////////////
// Retirement trace unit top level
// Attach to the core's fetch and stall, read trace records out
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "trace_params.svh"

module pipeline_trace_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      fetch_valid,
  input  logic [`XLEN-1:0]          fetch_pc,
  input  logic [`XLEN-1:0]          fetch_instr,
  input  logic                      stall,
  input  logic [`CLASS_W-1:0]       class_sel,
  output logic                      trace_valid,
  output logic [`XLEN-1:0]          trace_pc,
  output logic [`CLASS_W-1:0]       trace_class,
  output logic [`CYCLE_W-1:0]       trace_cycle,
  output logic [`STALL_W-1:0]       trace_stalls,
  output logic [`STALL_TOTAL_W-1:0] stall_total,
  output logic [`COUNT_W-1:0]       class_count
);

  // Tracker to recorder
  logic               ret_valid;
  logic [`XLEN-1:0]   ret_pc;
  logic [`XLEN-1:0]   ret_instr;
  logic [`STALL_W-1:0] ret_stalls;
  // Timer to recorder
  logic [`CYCLE_W-1:0] cycle_now;

  trace_stage_tracker u_tracker (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_valid (fetch_valid),
    .fetch_pc    (fetch_pc),
    .fetch_instr (fetch_instr),
    .stall       (stall),
    .ret_valid   (ret_valid),
    .ret_pc      (ret_pc),
    .ret_instr   (ret_instr),
    .ret_stalls  (ret_stalls)
  );

  trace_cycle_timer u_timer (
    .clk         (clk),
    .rst_n       (rst_n),
    .stall       (stall),
    .cycle_now   (cycle_now),
    .stall_total (stall_total)
  );

  trace_recorder u_recorder (
    .clk          (clk),
    .rst_n        (rst_n),
    .ret_valid    (ret_valid),
    .ret_pc       (ret_pc),
    .ret_instr    (ret_instr),
    .ret_stalls   (ret_stalls),
    .cycle_now    (cycle_now),
    .class_sel    (class_sel),
    .trace_valid  (trace_valid),
    .trace_pc     (trace_pc),
    .trace_class  (trace_class),  // Enum flattens onto the 4-bit port
    .trace_cycle  (trace_cycle),
    .trace_stalls (trace_stalls),
    .class_count  (class_count)
  );

endmodule

// ==== verification/trace_assertions.sv ====
//////////////////////////////////////////////////
// Stall rule checks on the shadow pipeline
// Bound into the stage tracker from the testbench
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "trace_params.svh"

module trace_assertions (
  input logic             clk,
  input logic             rst_n,
  input logic             stall,
  input logic             if_valid,   // IF slot valid
  input logic [`XLEN-1:0] if_pc,      // IF slot PC
  input logic             id_valid,   // ID slot valid
  input logic             ex_valid    // EX slot valid
);

  // Held IF slot keeps its PC
  if_pc_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (stall && if_valid) |=> (if_pc == $past(if_pc)))
    else $error("IF slot PC changed while stalled");

  // Stall pushes a bubble into execute
  ex_bubble: assert property (@(posedge clk) disable iff (!rst_n)
    stall |=> !ex_valid)
    else $error("EX slot valid right after a stall cycle");

  // Held slots are never dropped
  if_keep: assert property (@(posedge clk) disable iff (!rst_n)
    (stall && if_valid) |=> if_valid)
    else $error("IF slot lost its instruction while stalled");

  id_keep: assert property (@(posedge clk) disable iff (!rst_n)
    (stall && id_valid) |=> id_valid)
    else $error("ID slot lost its instruction while stalled");

endmodule

// ==== verification/trace_tb.sv ====
//////////////////////////////////////////////////
// Testbench of the retirement trace unit
// Random fetch and stall traffic against a five-slot model
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "trace_params.svh"

module trace_tb
  import rv_isa_pkg::*;
  import trace_pkg::*;
();

  localparam int NUM_INSTR   = 400;
  localparam int CLK_PERIOD  = 10;
  localparam int MAX_CYC_PER = 16;  // Generous bound on cycles per instruction
  localparam int WATCHDOG_NS = NUM_INSTR * MAX_CYC_PER * CLK_PERIOD + 2000;
  // Weighted opcode pool, last four entries decode as illegal
  localparam logic [6:0] OPCODE_POOL [16] = '{OP, OP, OP_IMM, OP_IMM, LOAD, STORE, BRANCH,
    JAL, JALR, LUI, AUIPC, SYSTEM, 7'h0b, 7'h7f, 7'b0110001, 7'b0000010};

  logic clk, rst_n, fetch_valid, stall, trace_valid;
  logic [`XLEN-1:0] fetch_pc, fetch_instr, trace_pc;
  logic [`CLASS_W-1:0] class_sel, trace_class;
  cycle_t trace_cycle;
  stall_cnt_t trace_stalls;
  stall_total_t stall_total;
  class_count_t class_count;

  // Reference model state
  logic             m_valid  [5];
  logic [`XLEN-1:0] m_pc     [5];
  logic [`XLEN-1:0] m_instr  [5];
  stall_cnt_t       m_stalls [5];
  cycle_t           m_cycle;          // Edges since reset release
  stall_total_t     m_stall_total;
  class_count_t     m_class_cnt [`NUM_CLASSES];
  logic             exp_valid;        // Record due in this cycle
  logic [`XLEN-1:0] exp_pc;
  op_class_t        exp_class;
  cycle_t           exp_cycle;
  stall_cnt_t       exp_stalls;
  logic [`XLEN-1:0] fetch_order [$];  // Sampled PCs, oldest first
  cycle_t           fetch_edge  [$];  // Model cycle right after sampling
  int sent, traced, value_errors, protocol_errors;

  pipeline_trace_top DUT (.*);

  bind trace_stage_tracker trace_assertions u_assertions (
    .clk      (clk),
    .rst_n    (rst_n),
    .stall    (stall),
    .if_valid (slot_valid[trace_pkg::STG_IF]),
    .if_pc    (slot_pc[trace_pkg::STG_IF]),
    .id_valid (slot_valid[trace_pkg::STG_ID]),
    .ex_valid (slot_valid[trace_pkg::STG_EX])
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Class straight from the ISA mapping rules
  function automatic op_class_t expected_class(input logic [`XLEN-1:0] instr);
    op_class_t cls;
    cls = CLS_ILLEGAL;                      // Low bits other than 11
    if (instr[1:0] == 2'b11) begin
      case (instr[6:0])
        OP:          cls = CLS_ALU;
        OP_IMM:      cls = CLS_ALU_IMM;
        LOAD:        cls = CLS_LOAD;
        STORE:       cls = CLS_STORE;
        BRANCH:      cls = CLS_BRANCH;
        JAL, JALR:   cls = CLS_JUMP;
        LUI, AUIPC:  cls = CLS_UPPER;
        SYSTEM:      cls = CLS_SYSTEM;
        default:     cls = CLS_ILLEGAL;
      endcase
    end
    return cls;
  endfunction

  //////////////////////////////////////////////////
  // Compare tasks, one per result type
  //////////////////////////////////////////////////
  task automatic check_pc(input string name, input logic [`XLEN-1:0] got, exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_class(input string name, input op_class_t got, exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_cycle(input string name, input cycle_t got, exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_stalls(input string name, input stall_cnt_t got, exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_stall_total(input string name, input stall_total_t got, exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_count(input string name, input class_count_t got, exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      value_errors++;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Reference model, advances on every edge out of reset
  //////////////////////////////////////////////////
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < 5; s++) m_valid[s] = 1'b0;
      for (int c = 0; c < `NUM_CLASSES; c++) m_class_cnt[c] = '0;
      m_cycle = '0;
      m_stall_total = '0;
      exp_valid = 1'b0;
    end else begin
      exp_valid = m_valid[STG_WB];          // WB slot leaves, record next cycle
      if (m_valid[STG_WB]) begin
        exp_pc     = m_pc[STG_WB];
        exp_class  = expected_class(m_instr[STG_WB]);
        exp_cycle  = m_cycle;               // Cycle count seen during WB
        exp_stalls = m_stalls[STG_WB];
        if (m_class_cnt[exp_class] != '1) m_class_cnt[exp_class]++;
      end
      if (stall && m_stall_total != '1) m_stall_total++;
      for (int s = STG_WB; s >= STG_MEM; s--) begin  // Back end always moves
        m_valid[s] = m_valid[s-1];
        m_pc[s] = m_pc[s-1];
        m_instr[s] = m_instr[s-1];
        m_stalls[s] = m_stalls[s-1];
      end
      if (stall) begin
        m_valid[STG_EX] = 1'b0;             // Bubble
        for (int s = STG_IF; s <= STG_ID; s++)
          if (m_valid[s] && m_stalls[s] != '1) m_stalls[s]++;
      end else begin
        for (int s = STG_EX; s >= STG_ID; s--) begin
          m_valid[s] = m_valid[s-1];
          m_pc[s] = m_pc[s-1];
          m_instr[s] = m_instr[s-1];
          m_stalls[s] = m_stalls[s-1];
        end
        m_valid[STG_IF] = fetch_valid;
        m_pc[STG_IF] = fetch_pc;
        m_instr[STG_IF] = fetch_instr;
        m_stalls[STG_IF] = '0;
        if (fetch_valid) begin
          fetch_order.push_back(fetch_pc);
          fetch_edge.push_back(m_cycle + 1'b1);
        end
      end
      m_cycle = m_cycle + 1'b1;
    end
  end

  // Outputs are sampled mid-cycle
  always @(negedge clk) begin
    cycle_t sample_edge;
    if (rst_n) begin
      check_stall_total("stall_total", stall_total, m_stall_total);
      if (trace_valid !== exp_valid) begin
        $display("Trace pulse at %0t is %b where %b was due", $time, trace_valid, exp_valid);
        protocol_errors++;
      end else if (trace_valid) begin
        check_pc("trace_pc", trace_pc, exp_pc);
        check_class("trace_class", op_class_t'(trace_class), exp_class);
        check_cycle("trace_cycle", trace_cycle, exp_cycle);
        check_stalls("trace_stalls", trace_stalls, exp_stalls);
        if (fetch_order.size() == 0) begin
          $display("Trace pulse at %0t with no instruction outstanding", $time);
          protocol_errors++;
        end else begin
          sample_edge = fetch_edge.pop_front();
          check_pc("trace_pc in fetch order", trace_pc, fetch_order.pop_front());
          check_cycle("trace latency", m_cycle - sample_edge, cycle_t'(5 + exp_stalls));
          traced++;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus and closing report
  //////////////////////////////////////////////////
  initial begin
    logic [31:0] rng;
    logic        next_valid;
    logic        next_stall;
    rng = 32'd75;
    {fetch_valid, stall, fetch_pc, fetch_instr, class_sel} = '0;
    {sent, traced, value_errors, protocol_errors} = '0;
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    while (sent < NUM_INSTR) begin
      @(posedge clk);
      rng = xorshift32(rng);
      next_valid = (rng[1:0] != 2'b00);    // 3 in 4
      next_stall = (rng[3:2] == 2'b00);    // 1 in 4
      fetch_valid <= next_valid;
      stall       <= next_stall;
      fetch_pc    <= 32'h0000_1000 + 32'(sent) * 4;
      rng = xorshift32(rng);
      fetch_instr <= {rng[31:7], OPCODE_POOL[rng[3:0]]};
      if (next_valid && !next_stall) sent++;  // Taken at the next edge
    end
    @(posedge clk);
    fetch_valid <= 1'b0;
    stall       <= 1'b0;
    while (traced < NUM_INSTR) @(posedge clk);
    for (int c = 0; c < `NUM_CLASSES; c++) begin  // Sweep the retire counts
      @(posedge clk);
      class_sel <= c[`CLASS_W-1:0];
      @(negedge clk);
      check_count("class_count", class_count, m_class_cnt[c]);
    end
    @(posedge clk);
    $display("Run done: %0d value errors, %0d protocol errors", value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired with %0d of %0d traces seen", traced, NUM_INSTR);
    $display("Something failed");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+include
hw/rv_isa_pkg.sv
hw/trace_pkg.sv
hw/trace_stage_tracker.sv
hw/trace_cycle_timer.sv
hw/trace_recorder.sv
hw/pipeline_trace_top.sv
verification/trace_assertions.sv
verification/trace_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the trace unit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f files.f --top-module trace_tb -o trace_sim

./obj_dir/trace_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Everything OK" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
